// ==== tb.f ====
cpc_pkg.sv
boot_mapper.sv
rom_map_table.sv
mf2_ctrl.sv
mf2_shadow.sv
cpc_mem_glue.sv
tb_clock.sv
tb_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_top.sv ====
// Testbench top: DUT, directed tests, compare tasks, timeout and summary
`timescale 1ns/1ns

module tb_top import cpc_pkg::*; ();

	localparam logic [31:0] seed       = 32'hca6b_516e;
	localparam logic        model_cfg  = 1'b1;
	localparam int          est_cycles = 500;            // All tests with margin
	localparam int          max_cycles = 4 * est_cycles;

	logic       clk_sys, por_reset, host_reset, reset;
	cpu_bus_t   cpu;
	dl_bus_t    dl;
	logic       key_nmi, model_sel;
	logic [1:0] mf2_mode;
	sdram_req_t mem_req;
	logic [7:0] mf2_dout;
	logic       nmi, mf2_active, model;

	int cycles = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign reset = por_reset || host_reset;   // Host holds reset over ROM loads

	tb_clock u_clock (
		.clk_sys(clk_sys),
		.reset  (por_reset)
	);

	cpc_mem_glue uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.dl        (dl),
		.key_nmi   (key_nmi),
		.model_sel (model_sel),
		.mf2_mode  (mf2_mode),
		.mem_req   (mem_req),
		.mf2_dout  (mf2_dout),
		.nmi       (nmi),
		.mf2_active(mf2_active),
		.model     (model)
	);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Timeout: tests still running after %0d cycles", max_cycles);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers and compare tasks
	////////////////////////////////////////

	task automatic next_cycle();
		@(negedge clk_sys);
	endtask

	// Page of ROM slot s as the loader places it
	function automatic logic [8:0] expected_slot_page(input logic [2:0] s);
		case (s[1:0])
			2'd0: return 9'h000;
			2'd1: return 9'h100;
			2'd2: return 9'h107;
			default: return 9'h1FF;
		endcase
	endfunction

	function automatic string req_text(input sdram_req_t r);
		return $sformatf("oe=%b we=%b addr=%h bank=%h din=%h",
			r.oe, r.we, r.addr, r.bank, r.din);
	endfunction

	task automatic check_req(input string name, input sdram_req_t exp, input sdram_req_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %s actual %s", name, req_text(exp), req_text(act));
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start)
			$display("Test %s done, ok", name);
		else begin
			tests_failed++;
			$display("Test %s done, %0d errors", name, errors - errs_at_start);
		end
	endtask

	// Download start is a rising edge of download
	task automatic begin_download(input logic [7:0] idx, input logic [15:0] ext);
		dl.download = 1'b0;
		dl.wr       = 1'b0;
		next_cycle();
		dl.download = 1'b1;
		dl.index    = idx;
		dl.file_ext = ext;
		next_cycle();
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_rom_slots();
		int          errs_at_start;
		int          s;
		logic [31:0] rnd;
		sdram_req_t  exp;
		errs_at_start = errors;
		host_reset = 1'b1;
		begin_download(idx_rom, 16'h0000);
		check_bit("rom_slots model", model_cfg, model);
		for (s = 0; s < 8; s++) begin
			rnd = $urandom;
			dl.addr = {8'd0, s[2:0], rnd[13:0]};
			dl.dout = rnd[31:24];
			dl.wr   = rnd[16];
			next_cycle();
			exp.oe   = 1'b0;
			exp.we   = rnd[16];
			exp.addr = {expected_slot_page(s[2:0]), rnd[13:0]};
			exp.bank = {1'b0, s[2]};   // Upper four slots in bank 1
			exp.din  = rnd[31:24];
			check_req("rom_slots", exp, mem_req);
		end
		rnd = $urandom;
		dl.addr = {7'd0, 4'd9, rnd[13:0]};
		dl.wr   = 1'b1;
		next_cycle();
		check_bit("rom_slots slot 9 we", 1'b0, mem_req.we);
		dl.wr = 1'b0;
		end_test("rom_slots", errs_at_start);
	endtask

	task automatic expansion_case(input string name, input logic [15:0] ext,
		input logic [7:0] k, input logic [8:0] exp_page);
		logic [31:0] rnd;
		sdram_req_t  exp;
		begin_download(idx_ext, ext);
		rnd = $urandom;
		dl.addr = {3'd0, k, rnd[13:0]};
		dl.dout = rnd[31:24];
		dl.wr   = 1'b1;
		next_cycle();
		exp.oe   = 1'b0;
		exp.we   = 1'b1;
		exp.addr = {exp_page, rnd[13:0]};
		exp.bank = {1'b0, model_cfg};
		exp.din  = rnd[31:24];
		check_req(name, exp, mem_req);
		dl.wr = 1'b0;
	endtask

	task automatic test_expansion();
		int          errs_at_start;
		logic [31:0] rnd;
		logic [7:0]  pg;
		errs_at_start = errors;
		host_reset = 1'b1;
		rnd = $urandom;
		pg  = 8'h1A + rnd[7:0];   // Offset page added to base page modulo 256
		expansion_case("expansion 1A", "1A", rnd[7:0], {1'b1, pg});
		expansion_case("expansion Q!", "Q!", 8'd0, 9'h1EE);
		expansion_case("expansion ZZ", "ZZ", 8'd0, 9'h000);
		end_test("expansion", errs_at_start);
	endtask

	task automatic test_rom_mask();
		int          errs_at_start;
		logic [31:0] rnd;
		errs_at_start = errors;
		host_reset = 1'b1;
		begin_download(idx_rom, 16'h0000);
		rnd = $urandom;
		dl.addr = {8'd0, 3'd2, rnd[13:0]};   // Slot 2 lands on page 107
		dl.dout = rnd[31:24];
		dl.wr   = 1'b1;
		next_cycle();
		dl.wr = 1'b0;
		next_cycle();
		dl.download = 1'b0;
		host_reset  = 1'b0;
		cpu.mem_rd   = 1'b1;
		cpu.mem_addr = {9'h107, rnd[13:0]};
		next_cycle();
		check_bit("rom_mask page 07 oe", 1'b1, mem_req.oe);
		cpu.mem_addr = {9'h130, rnd[13:0]};
		next_cycle();
		check_bit("rom_mask page 30 oe", 1'b0, mem_req.oe);
		cpu.mem_rd   = 1'b0;
		cpu.mem_addr = '0;
		end_test("rom_mask", errs_at_start);
	endtask

	task automatic test_mf2_entry();
		int          errs_at_start;
		logic [31:0] rnd;
		sdram_req_t  exp;
		errs_at_start = errors;
		key_nmi = 1'b1;
		next_cycle();
		check_bit("mf2_entry nmi", 1'b1, nmi);
		key_nmi = 1'b0;
		cpu.addr = 16'h0066;   // NMI fetch
		cpu.m1   = 1'b1;
		next_cycle();
		check_bit("mf2_entry nmi cleared", 1'b0, nmi);
		check_bit("mf2_entry active", 1'b1, mf2_active);
		rnd = $urandom;
		cpu.m1       = 1'b0;
		cpu.addr     = 16'h1234;
		cpu.mem_addr = 23'h001234;
		cpu.dout     = rnd[7:0];
		cpu.mem_rd   = 1'b1;
		next_cycle();
		exp.oe   = 1'b1;
		exp.we   = 1'b0;
		exp.addr = {9'h1FF, 14'h1234};   // Redirected into the MF2 ROM page
		exp.bank = {1'b0, model_cfg};
		exp.din  = rnd[7:0];
		check_req("mf2_entry rom read", exp, mem_req);
		cpu.mem_rd = 1'b0;
		cpu.mem_wr = 1'b1;
		next_cycle();
		check_bit("mf2_entry rom write we", 1'b0, mem_req.we);
		cpu.mem_wr = 1'b0;
		end_test("mf2_entry", errs_at_start);
	endtask

	task automatic test_shadow();
		int          errs_at_start;
		logic [31:0] rnd;
		logic [7:0]  data;
		errs_at_start = errors;
		rnd  = $urandom;
		data = {2'b10, rnd[5:0]};   // Gate array mode write
		cpu.addr  = {8'h7F, rnd[15:8]};
		cpu.dout  = data;
		cpu.io_wr = 1'b1;
		next_cycle();
		cpu.io_wr    = 1'b0;
		cpu.addr     = 16'h3FEF;
		cpu.mem_addr = 23'h003FEF;
		cpu.mem_rd   = 1'b1;
		next_cycle();
		next_cycle();
		check_byte("shadow mode byte", data, mf2_dout);
		cpu.addr     = 16'h4000;
		cpu.mem_addr = 23'h004000;
		next_cycle();
		check_byte("shadow outside window", 8'hFF, mf2_dout);
		cpu.mem_rd = 1'b0;
		end_test("shadow", errs_at_start);
	endtask

	task automatic test_exit_hide();
		int errs_at_start;
		errs_at_start = errors;
		cpu.addr  = 16'hFEEA;
		cpu.io_wr = 1'b1;
		next_cycle();
		check_bit("exit_hide FEEA", 1'b0, mf2_active);
		cpu.io_wr = 1'b0;
		next_cycle();
		cpu.addr = 16'h0065;   // Hide request
		cpu.m1   = 1'b1;
		next_cycle();
		cpu.m1 = 1'b0;
		next_cycle();
		cpu.addr  = 16'hFEE8;
		cpu.io_wr = 1'b1;
		next_cycle();
		check_bit("exit_hide FEE8 hidden", 1'b0, mf2_active);
		cpu.io_wr = 1'b0;
		mf2_mode  = 2'd2;
		next_cycle();
		key_nmi = 1'b1;
		next_cycle();
		check_bit("exit_hide disabled nmi", 1'b0, nmi);
		key_nmi = 1'b0;
		end_test("exit_hide", errs_at_start);
	endtask

	initial begin
		void'($urandom(seed));
		cpu        = '0;
		dl         = '0;
		key_nmi    = 1'b0;
		model_sel  = model_cfg;
		mf2_mode   = 2'd0;
		host_reset = 1'b0;
		wait (!por_reset);
		next_cycle();

		test_rom_slots();
		test_expansion();
		test_rom_mask();
		test_mf2_entry();
		test_shadow();
		test_exit_hide();

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
// Testbench clock and power-on reset generator
`timescale 1ns/1ns

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;   // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;   // Released away from the sampling edge
	end

endmodule

// ==== cpc_mem_glue.sv ====
// Top level memory glue: boot mapper, ROM map, MF2 control and shadow, SDRAM request mux
`timescale 1ns/1ns

module cpc_mem_glue import cpc_pkg::*; #(
	parameter int mf2_ram_aw = 13
) (
	input  logic       clk_sys,
	input  logic       reset,      // Held by the host during ROM download
	input  cpu_bus_t   cpu,
	input  dl_bus_t    dl,
	input  logic       key_nmi,
	input  logic       model_sel,
	input  logic [1:0] mf2_mode,
	output sdram_req_t mem_req,
	output logic [7:0] mf2_dout,
	output logic       nmi,
	output logic       mf2_active,
	output logic       model
);

	sdram_req_t            boot_req;
	logic [mem_addr_w-1:0] boot_addr;
	logic                  rom_mask;
	logic                  mf2_en;
	logic                  ram_sel, rom_sel;

	boot_mapper u_boot (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl       (dl),
		.model_sel(model_sel),
		.boot_req (boot_req),
		.boot_addr(boot_addr),
		.model    (model)
	);

	rom_map_table u_rom_map (
		.clk_sys  (clk_sys),
		.dl       (dl),
		.boot_addr(boot_addr),
		.mem_addr (cpu.mem_addr),
		.mf2_mode (mf2_mode),
		.rom_mask (rom_mask)
	);

	mf2_ctrl u_mf2_ctrl (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.key_nmi (key_nmi),
		.mf2_mode(mf2_mode),
		.nmi     (nmi),
		.mf2_en  (mf2_en)
	);

	mf2_shadow #(.mf2_ram_aw(mf2_ram_aw)) u_mf2_shadow (
		.clk_sys (clk_sys),
		.cpu     (cpu),
		.mf2_en  (mf2_en),
		.ram_sel (ram_sel),
		.rom_sel (rom_sel),
		.mf2_dout(mf2_dout)
	);

	assign mf2_active = mf2_en;

	////////////////////////////////////////
	// SDRAM request
	////////////////////////////////////////

	always_comb begin
		if (reset)
			mem_req = boot_req;   // Loader owns SDRAM
		else begin
			mem_req.oe   = cpu.mem_rd && !ram_sel && !rom_mask;
			mem_req.we   = cpu.mem_wr && !ram_sel && !rom_sel;   // MF2 ROM is read only
			mem_req.addr = rom_sel ? {mf2_page, cpu.addr[13:0]} : cpu.mem_addr;
			mem_req.bank = {1'b0, model};
			mem_req.din  = cpu.dout;
		end
	end

endmodule

// ==== mf2_shadow.sv ====
// Multiface Two window decode, register shadow address and 8 KB cartridge RAM
`timescale 1ns/1ns

module mf2_shadow import cpc_pkg::*; #(
	parameter int mf2_ram_aw = 13
) (
	input  logic       clk_sys,
	input  cpu_bus_t   cpu,
	input  logic       mf2_en,
	output logic       ram_sel,
	output logic       rom_sel,
	output logic [7:0] mf2_dout
);

	logic [7:0]            ram [2**mf2_ram_aw];
	logic [mf2_ram_aw-1:0] ram_a;
	logic [7:0]            ram_in, ram_out;
	logic                  ram_we;
	logic [12:0]           store_addr;
	logic [4:0]            pen_index;
	logic [3:0]            crtc_reg;
	logic                  old_io_wr;
	logic                  io_wr_edge;
	logic                  mf2_port;

	assign ram_sel  = mf2_en && (cpu.addr[15:13] == 3'b001);   // 2000-3FFF
	assign rom_sel  = mf2_en && (cpu.addr[15:13] == 3'b000);   // 0000-1FFF
	assign mf2_dout = (ram_sel && cpu.mem_rd) ? ram_out : 8'hFF;

	assign io_wr_edge = !old_io_wr && cpu.io_wr;
	assign mf2_port   = cpu.addr[15:2] == mf2_io_base;

	////////////////////////////////////////
	// Shadow address decode
	////////////////////////////////////////

	always_comb begin
		store_addr = '0;   // Not a shadowed register
		case (cpu.addr[15:8])
			8'h7F: begin   // Gate array function in bits 7:6
				case (cpu.dout[7:6])
					2'b00: store_addr = shadow_pen_idx;
					2'b01: store_addr = pen_index[4] ? shadow_border
						: (shadow_pen_col | {9'd0, pen_index[3:0]});
					2'b10: store_addr = shadow_mode;
					default: store_addr = shadow_banking;
				endcase
			end
			8'hBC: store_addr = shadow_crtc_sel;
			8'hBD: store_addr = shadow_crtc_val | {9'd0, crtc_reg};
			8'hF7: store_addr = shadow_ppi;       // 8255 control
			8'hDF: store_addr = shadow_upper_rom;
			default: store_addr = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		old_io_wr <= cpu.io_wr;

		if (io_wr_edge && !mf2_port && (|store_addr)) begin
			if (cpu.addr[15:8] == 8'h7F && cpu.dout[7:6] == 2'b00)
				pen_index <= cpu.dout[4:0];
			if (cpu.addr[15:8] == 8'hBC)
				crtc_reg <= cpu.dout[3:0];
			ram_a  <= store_addr[mf2_ram_aw-1:0];
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else if (cpu.mem_wr && ram_sel) begin   // CPU store into cartridge RAM
			ram_a  <= cpu.mem_addr[mf2_ram_aw-1:0];
			ram_in <= cpu.dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu.mem_addr[mf2_ram_aw-1:0];
			ram_we <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Cartridge RAM
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;   // Write-through
		end else
			ram_out <= ram[ram_a];
	end

endmodule

// ==== mf2_ctrl.sv ====
// Multiface Two NMI request, enable and hidden state
`timescale 1ns/1ns

module mf2_ctrl import cpc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  logic       key_nmi,
	input  logic [1:0] mf2_mode,   // 0 enabled, 1 hidden, 2 disabled
	output logic       nmi,
	output logic       mf2_en
);

	logic old_key_nmi, old_m1, old_io_wr;
	logic key_edge, m1_edge, io_wr_edge;
	logic hidden;

	assign key_edge   = !old_key_nmi && key_nmi;
	assign m1_edge    = !old_m1 && cpu.m1;
	assign io_wr_edge = !old_io_wr && cpu.io_wr;

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi;
		old_m1      <= cpu.m1;
		old_io_wr   <= cpu.io_wr;
	end

	////////////////////////////////////////
	// State
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= |mf2_mode;
		end else begin
			if (key_edge && !mf2_en && !mf2_mode[1])
				nmi <= 1'b1;   // Red button

			// Page the cartridge in once the CPU takes the NMI
			if (nmi && m1_edge && (cpu.addr == nmi_vector)) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (m1_edge && (cpu.addr == hide_vector))
				hidden <= 1'b1;   // Software asks to stay invisible

			// FEE8 pages in, FEEA pages out
			if (io_wr_edge && (cpu.addr[15:2] == mf2_io_base))
				mf2_en <= !cpu.addr[1] && !hidden;
		end
	end

	a_nmi_handoff: assert property (@(posedge clk_sys) disable iff (reset)
		(nmi && mf2_en) |=> !(nmi && mf2_en));

endmodule

// ==== rom_map_table.sv ====
// Upper ROM presence table and read mask for empty ROM pages
`timescale 1ns/1ns

module rom_map_table import cpc_pkg::*; (
	input  logic                  clk_sys,
	input  dl_bus_t               dl,
	input  logic [mem_addr_w-1:0] boot_addr,
	input  logic [mem_addr_w-1:0] mem_addr,
	input  logic [1:0]            mf2_mode,
	output logic                  rom_mask
);

	logic [255:0] rom_map;   // One flag per upper ROM page
	logic [7:0]   map_addr;
	logic         rom_dl;
	logic         old_wr, old_download;

	assign rom_dl = dl.download && (dl.index == idx_rom);

	always_ff @(posedge clk_sys) begin
		old_wr       <= dl.wr;
		old_download <= dl.download;

		// Fresh table for every ROM image
		if (rom_dl && !old_download)
			rom_map <= '0;
		else if (rom_dl && old_wr && !dl.wr && boot_addr[mem_addr_w-1])
			rom_map[boot_addr[21:14]] <= 1'b1;   // Byte done
	end

	always_ff @(posedge clk_sys)
		map_addr <= mem_addr[21:14];

	// Page FF holds the MF2 ROM and is hidden when the cartridge is off
	assign rom_mask = mem_addr[mem_addr_w-1] &&
		(!rom_map[map_addr] || ((&map_addr) && mf2_mode[1]));

	// A loaded page stays present until the next ROM image starts
	a_map_sticky: assert property (@(posedge clk_sys)
		(rom_dl && old_download) |=> ((rom_map & $past(rom_map)) == $past(rom_map)));

endmodule

// ==== boot_mapper.sv ====
// Boot loader address mapper: ROM slot placement, expansion page from extension, model latch
`timescale 1ns/1ns

module boot_mapper import cpc_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  dl_bus_t               dl,
	input  logic                  model_sel,
	output sdram_req_t            boot_req,
	output logic [mem_addr_w-1:0] boot_addr,
	output logic                  model
);

	// {valid, value} for one hex character
	function automatic logic [4:0] hex_nib(input logic [7:0] c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	logic              rom_dl, ext_dl;
	logic              old_download, old_wr;
	logic              combo;          // Set by Z0 to move to the MF2 page after the first
	logic [page_w-1:0] page;           // Expansion base page
	logic [page_w-1:0] ext_page;
	logic [page_w-1:0] boot_page;
	logic [4:0]        nib_hi, nib_lo;
	logic [10:0]       slot;

	assign rom_dl = dl.download && (dl.index == idx_rom);
	assign ext_dl = dl.download && (dl.index == idx_ext);
	assign slot   = dl.addr[24:14];

	assign nib_hi   = hex_nib(dl.file_ext[15:8]);
	assign nib_lo   = hex_nib(dl.file_ext[7:0]);
	assign ext_page = (nib_hi[4] && nib_lo[4]) ? {1'b1, nib_hi[3:0], nib_lo[3:0]} : blank_page;

	////////////////////////////////////////
	// Expansion page, set at download start
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		old_download <= dl.download;
		old_wr       <= dl.wr;

		if (ext_dl && old_wr && !dl.wr && combo && (&boot_addr[13:0])) begin
			combo <= 1'b0;
			page  <= mf2_page;
		end

		if (!old_download && dl.download && ext_dl) begin
			combo <= 1'b0;
			if (dl.file_ext == "ZZ")
				page <= '0;
			else if (dl.file_ext == "Z0") begin
				page  <= '0;
				combo <= 1'b1;
			end else
				page <= ext_page;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			model <= model_sel;   // 6128 or 664 chosen on reset
	end

	////////////////////////////////////////
	// Download byte to SDRAM
	////////////////////////////////////////

	always_comb begin
		boot_req.oe   = 1'b0;
		boot_req.we   = (rom_dl || ext_dl) && dl.wr;
		boot_req.din  = dl.dout;
		boot_req.bank = 2'd0;
		boot_page     = '1;
		if (ext_dl) begin
			boot_page     = {page[8], page[7:0] + dl.addr[21:14]};
			boot_req.bank = {1'b0, model};
		end else if (slot < 11'd8) begin
			boot_page     = slot_page[slot[1:0]];
			boot_req.bank = {1'b0, slot[2]};   // Slots 4..7 go to bank 1
		end else
			boot_req.we = 1'b0;                // Past the last slot
		boot_req.addr = {boot_page, dl.addr[13:0]};
	end

	assign boot_addr = boot_req.addr;

endmodule

// ==== cpc_pkg.sv ====
// Shared bus structs, SDRAM page constants, download indices and MF2 shadow addresses
package cpc_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int mem_addr_w = 23;             // SDRAM byte address
	localparam int page_w     = 9;              // Upper ROM flag + 8-bit page

	////////////////////////////////////////
	// SDRAM pages and download slots
	////////////////////////////////////////

	localparam logic [page_w-1:0] mf2_page   = 9'h1FF; // Multiface ROM
	localparam logic [page_w-1:0] blank_page = 9'h1EE; // Unused page for a bad extension

	// Pages for slots 0..3 and again for slots 4..7 in bank 1
	localparam logic [3:0][page_w-1:0] slot_page = {9'h1FF, 9'h107, 9'h100, 9'h000};

	localparam logic [7:0] idx_rom = 8'd0;
	localparam logic [7:0] idx_ext = 8'd3;

	////////////////////////////////////////
	// Multiface Two
	////////////////////////////////////////

	localparam logic [15:0] nmi_vector  = 16'h0066;
	localparam logic [15:0] hide_vector = 16'h0065;
	localparam logic [13:0] mf2_io_base = 14'b11111110111010; // FEE8 / FEEA

	// Where each hardware register write lands in cartridge RAM
	localparam logic [12:0] shadow_pen_idx   = 13'h1FCF;
	localparam logic [12:0] shadow_pen_col   = 13'h1F90; // + pen index
	localparam logic [12:0] shadow_border    = 13'h1FDF;
	localparam logic [12:0] shadow_mode      = 13'h1FEF;
	localparam logic [12:0] shadow_banking   = 13'h1FFF;
	localparam logic [12:0] shadow_crtc_sel  = 13'h1CFF;
	localparam logic [12:0] shadow_crtc_val  = 13'h1DB0; // + CRTC register
	localparam logic [12:0] shadow_ppi       = 13'h17FF;
	localparam logic [12:0] shadow_upper_rom = 13'h1AAC;

	////////////////////////////////////////
	// Bus structs
	////////////////////////////////////////

	typedef struct packed {
		logic [15:0]           addr;     // Z80 address
		logic [mem_addr_w-1:0] mem_addr; // After motherboard banking
		logic [7:0]            dout;
		logic                  mem_rd;
		logic                  mem_wr;
		logic                  io_rd;
		logic                  io_wr;
		logic                  m1;
	} cpu_bus_t;

	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  dout;
		logic [15:0] file_ext; // Two ASCII chars
	} dl_bus_t;

	typedef struct packed {
		logic                  oe;
		logic                  we;
		logic [mem_addr_w-1:0] addr;
		logic [1:0]            bank;
		logic [7:0]            din;
	} sdram_req_t;

endpackage
